/* include/exec_defines.svh */
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Datapath sizes
`define EXEC_DATA_W 32
`define EXEC_REG_W 5
`define EXEC_LANES 4
`define EXEC_CMD_W 4
`define EXEC_FLAG_W 5

// Flag word layout, sign at the top
`define EXEC_FLAG_SF 4
`define EXEC_FLAG_OF 3
`define EXEC_FLAG_CF 2
`define EXEC_FLAG_PF 1
`define EXEC_FLAG_ZF 0

// ALU command codes
`define EXEC_CMD_AND 4'h0
`define EXEC_CMD_OR 4'h1
`define EXEC_CMD_XOR 4'h2
`define EXEC_CMD_ADD 4'h3
`define EXEC_CMD_SUB 4'h4
`define EXEC_CMD_SHL 4'h5
`define EXEC_CMD_SHR 4'h6
`define EXEC_CMD_SAR 4'h7

`endif

/* verilog/exec_pkg.sv */
`include "exec_defines.svh"

package exec_pkg;

	typedef enum logic [`EXEC_CMD_W-1:0] {
		AND = `EXEC_CMD_AND,
		OR = `EXEC_CMD_OR,
		XOR = `EXEC_CMD_XOR,
		ADD = `EXEC_CMD_ADD,
		SUB = `EXEC_CMD_SUB,
		SHL = `EXEC_CMD_SHL,
		SHR = `EXEC_CMD_SHR,
		SAR = `EXEC_CMD_SAR
	} alu_cmd_e;

	typedef enum logic [1:0] {
		ALU = 2'd0,
		LOAD = 2'd1,
		STORE = 2'd2
	} unit_e;

	// Access size
	typedef enum logic [1:0] {
		BYTE = 2'd0,
		HALF = 2'd1,
		WORD = 2'd2
	} order_e;

	// Decoded op from the previous stage
	typedef struct packed {
		logic valid;
		unit_e unit;
		alu_cmd_e cmd;
		order_e order;
		logic [`EXEC_DATA_W-1:0] src0;
		logic [`EXEC_DATA_W-1:0] src1;
		logic [`EXEC_REG_W-1:0] dest;
		logic writeback;
		logic flags_write;
	} exec_op_t;

	// Data port request, rw set for a write
	typedef struct packed {
		logic req;
		logic rw;
		logic [`EXEC_LANES-1:0] mask;
		logic [`EXEC_DATA_W-1:0] addr;
		logic [`EXEC_DATA_W-1:0] wdata;
	} dataio_req_t;

	typedef struct packed {
		logic valid;
		logic writeback;
		logic [`EXEC_REG_W-1:0] dest;
		logic [`EXEC_DATA_W-1:0] data;
	} wb_t;

	typedef struct packed {
		logic [`EXEC_DATA_W-1:0] data;
		logic [`EXEC_FLAG_W-1:0] flags;
	} alu_res_t;

endpackage

/* verilog/exec_alu.sv */
`include "exec_defines.svh"

module exec_alu (
	input exec_pkg::alu_cmd_e cmd,
	input logic [`EXEC_DATA_W-1:0] src0,
	input logic [`EXEC_DATA_W-1:0] src1,
	output exec_pkg::alu_res_t res
);
	localparam int W = `EXEC_DATA_W;
	localparam int SHW = $clog2(`EXEC_DATA_W);

	logic is_sub;
	logic [W-1:0] add_b;
	logic [W:0] sum;
	logic [SHW-1:0] shamt;
	logic [W:0] shl_wide;
	logic [W:0] shr_wide;
	logic [W:0] sar_wide;
	logic [W-1:0] data;
	logic carry;
	logic overflow;

	// Subtract as add of the inverted operand plus one
	assign is_sub = (cmd == exec_pkg::SUB);
	assign add_b = is_sub ? ~src1 : src1;
	assign sum = {1'b0, src0} + {1'b0, add_b} + {{W{1'b0}}, is_sub};

	// One spare bit catches the last bit shifted out
	assign shamt = src1[SHW-1:0];
	assign shl_wide = {1'b0, src0} << shamt;
	assign shr_wide = {src0, 1'b0} >> shamt;
	assign sar_wide = $signed({src0, 1'b0}) >>> shamt;

	always_comb begin
		data = '0;
		carry = 1'b0;
		overflow = 1'b0;
		case (cmd)
			exec_pkg::AND: data = src0 & src1;
			exec_pkg::OR: data = src0 | src1;
			exec_pkg::XOR: data = src0 ^ src1;
			exec_pkg::ADD, exec_pkg::SUB: begin
				data = sum[W-1:0];
				// Borrow is the inverted carry out
				carry = sum[W] ^ is_sub;
				overflow = (src0[W-1] == add_b[W-1]) && (sum[W-1] != src0[W-1]);
			end
			exec_pkg::SHL: begin
				data = shl_wide[W-1:0];
				carry = shl_wide[W];
			end
			exec_pkg::SHR: begin
				data = shr_wide[W:1];
				carry = shr_wide[0];
			end
			exec_pkg::SAR: begin
				data = sar_wide[W:1];
				carry = sar_wide[0];
			end
			default: data = '0;
		endcase
	end

	always_comb begin
		res.data = data;
		res.flags = '0;
		res.flags[`EXEC_FLAG_SF] = data[W-1];
		res.flags[`EXEC_FLAG_OF] = overflow;
		res.flags[`EXEC_FLAG_CF] = carry;
		// Parity here is just the low result bit
		res.flags[`EXEC_FLAG_PF] = data[0];
		res.flags[`EXEC_FLAG_ZF] = (data == '0);
	end

endmodule

/* verilog/exec_ldst.sv */
`include "exec_defines.svh"

module exec_ldst (
	input logic iCLOCK,
	input logic inRESET,
	input exec_pkg::exec_op_t op,
	input logic accept,
	input logic dataio_busy,
	input logic dataio_ack,
	input logic [`EXEC_DATA_W-1:0] dataio_rdata,
	output exec_pkg::dataio_req_t dataio,
	output logic [`EXEC_DATA_W-1:0] load_data
);
	localparam int W = `EXEC_DATA_W;
	localparam int LANES = `EXEC_LANES;
	localparam int LW = $clog2(`EXEC_LANES);

	logic is_store;
	logic is_mem;
	logic [W-1:0] addr;
	logic [LW-1:0] lane;
	logic [LANES-1:0] mask;
	logic [W-1:0] wdata;
	logic req_q;
	logic rw_q;
	logic [LANES-1:0] mask_q;
	logic [W-1:0] addr_q;
	logic [W-1:0] wdata_q;
	logic [LW-1:0] lane_q;
	exec_pkg::order_e order_q;
	logic [W-1:0] shifted;

	assign is_store = (op.unit == exec_pkg::STORE);
	assign is_mem = accept && (is_store || op.unit == exec_pkg::LOAD);

	// Stores carry their data in src1, so src0 alone is the address
	assign addr = is_store ? op.src0 : op.src0 + op.src1;

	// Lane offset, rounded down to the access size
	always_comb begin
		case (op.order)
			exec_pkg::BYTE: lane = addr[LW-1:0];
			exec_pkg::HALF: lane = {addr[LW-1], 1'b0};
			default: lane = '0;
		endcase
	end

	// Lane mask and store data moved up to its lanes
	always_comb begin
		case (op.order)
			exec_pkg::BYTE: begin
				mask = LANES'(1) << lane;
				wdata = W'(op.src1[7:0]) << {lane, 3'b000};
			end
			exec_pkg::HALF: begin
				mask = LANES'(3) << lane;
				wdata = W'(op.src1[15:0]) << {lane, 3'b000};
			end
			default: begin
				mask = '1;
				wdata = op.src1;
			end
		endcase
	end

	// Request level, dropped on the first edge the port is free
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			req_q <= 1'b0;
		end
		else if (is_mem) begin
			req_q <= 1'b1;
		end
		else if (req_q && !dataio_busy) begin
			req_q <= 1'b0;
		end
	end

	// Request fields stay put until the next memory op
	always_ff @(posedge iCLOCK) begin
		if (is_mem) begin
			rw_q <= is_store;
			mask_q <= mask;
			addr_q <= addr;
			wdata_q <= wdata;
			lane_q <= lane;
			order_q <= op.order;
		end
	end

	assign dataio = '{req: req_q, rw: rw_q, mask: mask_q, addr: addr_q, wdata: wdata_q};

	// Returned word shifted down to lane zero
	assign shifted = dataio_rdata >> {lane_q, 3'b000};

	always_comb begin
		load_data = '0;
		if (dataio_ack) begin
			case (order_q)
				exec_pkg::BYTE: load_data = W'(shifted[7:0]);
				exec_pkg::HALF: load_data = W'(shifted[15:0]);
				default: load_data = shifted;
			endcase
		end
	end

endmodule

/* verilog/exec_control.sv */
`include "exec_defines.svh"

module exec_control (
	input logic iCLOCK,
	input logic inRESET,
	input exec_pkg::exec_op_t op,
	input exec_pkg::alu_res_t alu,
	input logic [`EXEC_DATA_W-1:0] load_data,
	input logic dataio_ack,
	output logic accept,
	output logic lock,
	output exec_pkg::wb_t wb,
	output logic [`EXEC_FLAG_W-1:0] flags
);
	typedef enum logic [1:0] {
		ST_NORMAL,
		ST_LOAD_WAIT,
		ST_STORE_WAIT
	} state_e;

	state_e state;
	logic is_load;
	logic is_store;
	logic is_alu;
	logic wb_valid;
	logic wb_writeback;
	logic [`EXEC_REG_W-1:0] wb_dest;
	logic [`EXEC_DATA_W-1:0] wb_data;

	assign is_load = (op.unit == exec_pkg::LOAD);
	assign is_store = (op.unit == exec_pkg::STORE);
	assign is_alu = !is_load && !is_store;

	// Previous stage holds while a memory access is outstanding
	assign lock = (state != ST_NORMAL);
	assign accept = op.valid && !lock;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_NORMAL;
		end
		else begin
			case (state)
				ST_NORMAL: begin
					if (accept && is_load) begin
						state <= ST_LOAD_WAIT;
					end
					else if (accept && is_store) begin
						state <= ST_STORE_WAIT;
					end
				end
				default: begin
					// Both wait states end on the acknowledge
					if (dataio_ack) begin
						state <= ST_NORMAL;
					end
				end
			endcase
		end
	end

	// Writeback strobe and flag register
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wb_valid <= 1'b0;
			wb_writeback <= 1'b0;
			flags <= '0;
		end
		else begin
			wb_valid <= 1'b0;
			if (accept) begin
				// Memory ops report later, on the acknowledge
				wb_valid <= is_alu;
				wb_writeback <= op.writeback && !is_store;
				if (is_alu && op.flags_write) begin
					flags <= alu.flags;
				end
			end
			else if (lock && dataio_ack) begin
				wb_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			wb_dest <= op.dest;
			wb_data <= alu.data;
		end
		else if (state == ST_LOAD_WAIT && dataio_ack) begin
			wb_data <= load_data;
		end
	end

	assign wb = '{valid: wb_valid, writeback: wb_writeback, dest: wb_dest, data: wb_data};

endmodule

/* verilog/exec_top.sv */
`include "exec_defines.svh"

module exec_top (
	input logic iCLOCK,
	input logic inRESET,
	input exec_pkg::exec_op_t op,
	input logic dataio_busy,
	input logic dataio_ack,
	input logic [`EXEC_DATA_W-1:0] dataio_rdata,
	output logic lock,
	output exec_pkg::dataio_req_t dataio,
	output exec_pkg::wb_t wb,
	output logic [`EXEC_FLAG_W-1:0] flags
);
	logic accept;
	exec_pkg::alu_res_t alu_res;
	logic [`EXEC_DATA_W-1:0] load_data;

	exec_alu exec_alu_inst (
		.cmd(op.cmd),
		.src0(op.src0),
		.src1(op.src1),
		.res(alu_res)
	);

	exec_ldst exec_ldst_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.op(op),
		.accept(accept),
		.dataio_busy(dataio_busy),
		.dataio_ack(dataio_ack),
		.dataio_rdata(dataio_rdata),
		.dataio(dataio),
		.load_data(load_data)
	);

	exec_control exec_control_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.op(op),
		.alu(alu_res),
		.load_data(load_data),
		.dataio_ack(dataio_ack),
		.accept(accept),
		.lock(lock),
		.wb(wb),
		.flags(flags)
	);

endmodule

/* dv/exec_asserts.sv */
`include "exec_defines.svh"

module exec_asserts (
	input logic iCLOCK,
	input logic inRESET,
	input logic lock,
	input logic dataio_busy,
	input exec_pkg::dataio_req_t dataio
);
	timeunit 1ns;
	timeprecision 1ns;

	// Back-pressure freezes the whole request
	req_stable_while_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		dataio.req && dataio_busy |=> $stable(dataio))
		else $error("Data port request changed while the port was busy");

	req_implies_lock: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		dataio.req |-> lock)
		else $error("Data port request is up without lock");

	// First edge out of reset
	quiet_after_reset: assert property (@(posedge iCLOCK)
		$rose(inRESET) |-> !lock && !dataio.req)
		else $error("Lock or request high right after reset release");

endmodule

bind exec_top exec_asserts exec_asserts_inst (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.lock(lock),
	.dataio_busy(dataio_busy),
	.dataio(dataio)
);

/* dv/exec_tb.sv */
`include "exec_defines.svh"

module exec_tb;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLK_PERIOD = 10;
	localparam int N_OPS = 27;

	typedef struct packed {
		exec_pkg::unit_e unit;
		exec_pkg::alu_cmd_e cmd;
		exec_pkg::order_e order;
		logic [31:0] src0;
		logic [31:0] src1;
		logic flags_write;
		logic [31:0] exp_data;
		logic [31:0] exp_addr;
		logic [3:0] exp_mask;
		logic [`EXEC_FLAG_W-1:0] exp_flags;
	} entry_t;

	logic iCLOCK = 1'b0;
	logic inRESET;
	exec_pkg::exec_op_t op;
	logic dataio_busy;
	logic dataio_ack;
	logic [31:0] dataio_rdata;
	logic lock;
	exec_pkg::dataio_req_t dataio;
	exec_pkg::wb_t wb;
	logic [`EXEC_FLAG_W-1:0] flags;

	entry_t ops [N_OPS];
	int n_loaded = 0;
	logic [31:0] ref_mem [16];
	logic [31:0] mem [16];
	exec_pkg::dataio_req_t captured;
	int pend_q [$];
	int value_errors = 0;
	int other_errors = 0;

	exec_top exec_top_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.op(op),
		.dataio_busy(dataio_busy),
		.dataio_ack(dataio_ack),
		.dataio_rdata(dataio_rdata),
		.lock(lock),
		.dataio(dataio),
		.wb(wb),
		.flags(flags)
	);

	always #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;

	function automatic logic [31:0] fill_word(int i);
		return 32'(32'h0101_0101 * (i + 1) ^ 32'h5a00_c300);
	endfunction

	// Reference ALU, result in the upper bits and flags below
	function automatic logic [36:0] alu_model(exec_pkg::alu_cmd_e cmd, logic [31:0] a,
			logic [31:0] b);
		logic [31:0] r;
		logic c;
		logic v;
		int n;
		n = int'(b[4:0]);
		c = 1'b0;
		v = 1'b0;
		case (cmd)
			exec_pkg::AND: r = a & b;
			exec_pkg::OR: r = a | b;
			exec_pkg::XOR: r = a ^ b;
			exec_pkg::ADD: begin
				{c, r} = {1'b0, a} + {1'b0, b};
				v = (a[31] == b[31]) && (r[31] != a[31]);
			end
			exec_pkg::SUB: begin
				r = a - b;
				c = a < b;
				v = (a[31] != b[31]) && (r[31] != a[31]);
			end
			exec_pkg::SHL: begin
				r = a << n;
				c = (n == 0) ? 1'b0 : a[32 - n];
			end
			exec_pkg::SHR: begin
				r = a >> n;
				c = (n == 0) ? 1'b0 : a[n - 1];
			end
			default: begin
				r = $signed(a) >>> n;
				c = (n == 0) ? 1'b0 : a[n - 1];
			end
		endcase
		return {r, r[31], v, c, r[0], r == 32'h0};
	endfunction

	function automatic logic [3:0] lane_mask(exec_pkg::order_e order, logic [31:0] addr);
		case (order)
			exec_pkg::BYTE: return 4'b0001 << addr[1:0];
			exec_pkg::HALF: return addr[1] ? 4'b1100 : 4'b0011;
			default: return 4'b1111;
		endcase
	endfunction

	// Store data byte that lands in lane k
	function automatic logic [7:0] store_byte(exec_pkg::order_e order, logic [31:0] d, int k);
		case (order)
			exec_pkg::BYTE: return d[7:0];
			exec_pkg::HALF: return d[8 * (k % 2) +: 8];
			default: return d[8 * k +: 8];
		endcase
	endfunction

	function automatic logic [31:0] align_load(exec_pkg::order_e order, logic [31:0] addr,
			logic [31:0] word);
		case (order)
			exec_pkg::BYTE: return {24'h0, word[8 * addr[1:0] +: 8]};
			exec_pkg::HALF: return addr[1] ? {16'h0, word[31:16]} : {16'h0, word[15:0]};
			default: return word;
		endcase
	endfunction

	task automatic add_op(exec_pkg::unit_e unit, exec_pkg::alu_cmd_e cmd,
			exec_pkg::order_e order, logic [31:0] a, logic [31:0] b, logic fw);
		ops[n_loaded] = '0;
		ops[n_loaded].unit = unit;
		ops[n_loaded].cmd = cmd;
		ops[n_loaded].order = order;
		ops[n_loaded].src0 = a;
		ops[n_loaded].src1 = b;
		ops[n_loaded].flags_write = fw;
		n_loaded++;
	endtask

	task automatic alu_op(exec_pkg::alu_cmd_e cmd, logic [31:0] a, logic [31:0] b, logic fw);
		add_op(exec_pkg::ALU, cmd, exec_pkg::WORD, a, b, fw);
	endtask

	task automatic mem_op(exec_pkg::unit_e unit, exec_pkg::order_e order, logic [31:0] a,
			logic [31:0] b);
		add_op(unit, exec_pkg::AND, order, a, b, 1'b0);
	endtask

	task automatic load_table();
		alu_op(exec_pkg::AND, 32'hffff_00ff, 32'h0f0f_0f0f, 1'b1);
		alu_op(exec_pkg::OR, 32'h0, 32'h0, 1'b1);
		alu_op(exec_pkg::XOR, 32'ha5a5_a5a5, 32'hffff_ffff, 1'b0);
		alu_op(exec_pkg::ADD, 32'hffff_ffff, 32'h1, 1'b1);
		alu_op(exec_pkg::ADD, 32'h7fff_ffff, 32'h1, 1'b1);
		alu_op(exec_pkg::SUB, 32'h0, 32'h1, 1'b1);
		alu_op(exec_pkg::SUB, 32'h8000_0000, 32'h1, 1'b1);
		alu_op(exec_pkg::SHL, 32'h8000_0001, 32'h1, 1'b1);
		alu_op(exec_pkg::SHR, 32'h3, 32'h1, 1'b1);
		alu_op(exec_pkg::SAR, 32'h8000_0000, 32'h1f, 1'b1);
		alu_op(exec_pkg::SHL, 32'h1234_5678, 32'h20, 1'b1);
		mem_op(exec_pkg::STORE, exec_pkg::WORD, 32'h10, 32'hdead_beef);
		mem_op(exec_pkg::LOAD, exec_pkg::WORD, 32'h8, 32'h8);
		// Held behind the load above
		alu_op(exec_pkg::ADD, 32'h5, 32'h6, 1'b0);
		mem_op(exec_pkg::STORE, exec_pkg::BYTE, 32'h20, 32'h11);
		mem_op(exec_pkg::STORE, exec_pkg::BYTE, 32'h21, 32'h22);
		mem_op(exec_pkg::STORE, exec_pkg::BYTE, 32'h22, 32'h33);
		mem_op(exec_pkg::STORE, exec_pkg::BYTE, 32'h23, 32'h44);
		mem_op(exec_pkg::STORE, exec_pkg::HALF, 32'h24, 32'haaaa_5555);
		mem_op(exec_pkg::STORE, exec_pkg::HALF, 32'h26, 32'h1234);
		mem_op(exec_pkg::LOAD, exec_pkg::BYTE, 32'h20, 32'h3);
		mem_op(exec_pkg::LOAD, exec_pkg::BYTE, 32'h20, 32'h1);
		mem_op(exec_pkg::LOAD, exec_pkg::HALF, 32'h24, 32'h0);
		mem_op(exec_pkg::LOAD, exec_pkg::HALF, 32'h24, 32'h2);
		mem_op(exec_pkg::LOAD, exec_pkg::WORD, 32'h1c, 32'h4);
		mem_op(exec_pkg::LOAD, exec_pkg::HALF, 32'h30, 32'h2);
		alu_op(exec_pkg::SUB, 32'h5, 32'h5, 1'b1);
	endtask

	// Walks the table in order with a reference memory and flag register
	task automatic fill_expected();
		logic [`EXEC_FLAG_W-1:0] fl;
		logic [36:0] res;
		logic [31:0] addr;
		int i;
		int k;
		fl = '0;
		for (i = 0; i < 16; i++) begin
			ref_mem[i] = fill_word(i);
		end
		for (i = 0; i < N_OPS; i++) begin
			if (ops[i].unit == exec_pkg::ALU) begin
				res = alu_model(ops[i].cmd, ops[i].src0, ops[i].src1);
				ops[i].exp_data = res[36:5];
				if (ops[i].flags_write) begin
					fl = res[4:0];
				end
			end
			else begin
				if (ops[i].unit == exec_pkg::STORE) begin
					addr = ops[i].src0;
				end
				else begin
					addr = ops[i].src0 + ops[i].src1;
				end
				ops[i].exp_addr = addr;
				ops[i].exp_mask = lane_mask(ops[i].order, addr);
				for (k = 0; k < 4; k++) begin
					if (ops[i].unit == exec_pkg::STORE && ops[i].exp_mask[k]) begin
						ref_mem[addr[5:2]][8 * k +: 8] = store_byte(ops[i].order, ops[i].src1, k);
					end
				end
				ops[i].exp_data = align_load(ops[i].order, addr, ref_mem[addr[5:2]]);
			end
			ops[i].exp_flags = fl;
		end
	endtask

	task automatic compare(string what, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic watch_writebacks();
		int idx;
		entry_t e;
		forever begin
			@(negedge iCLOCK);
			if (wb.valid === 1'b1) begin
				if (pend_q.size() == 0) begin
					other_errors++;
					$display("A writeback appeared at %0t ns with nothing outstanding", $time);
				end
				else begin
					idx = pend_q.pop_front();
					e = ops[idx];
					compare("wb.dest", 32'(wb.dest), 32'(idx));
					compare("flags", 32'(flags), 32'(e.exp_flags));
					if (e.unit == exec_pkg::STORE) begin
						compare("store wb.writeback", 32'(wb.writeback), 32'h0);
					end
					else begin
						compare("wb.writeback", 32'(wb.writeback), 32'(idx[0]));
						compare("wb.data", wb.data, e.exp_data);
					end
					if (e.unit != exec_pkg::ALU) begin
						compare("request mask", 32'(captured.mask), 32'(e.exp_mask));
						compare("request addr", captured.addr, e.exp_addr);
						compare("request rw", 32'(captured.rw), 32'(e.unit == exec_pkg::STORE));
					end
				end
			end
		end
	endtask

	// Data port model with random back-pressure and acknowledge delay
	initial begin
		int i;
		int stall;
		logic [3:0] idx;
		dataio_busy = 1'b0;
		dataio_ack = 1'b0;
		dataio_rdata = '0;
		for (i = 0; i < 16; i++) begin
			mem[i] = fill_word(i);
		end
		forever begin
			@(negedge iCLOCK);
			if (inRESET === 1'b1 && dataio.req === 1'b1) begin
				stall = $urandom_range(3, 0);
				repeat (stall) begin
					dataio_busy = 1'b1;
					@(negedge iCLOCK);
				end
				dataio_busy = 1'b0;
				captured = dataio;
				@(negedge iCLOCK);
				repeat ($urandom_range(2, 0)) @(negedge iCLOCK);
				idx = captured.addr[5:2];
				for (i = 0; i < 4; i++) begin
					if (captured.rw && captured.mask[i]) begin
						mem[idx][8 * i +: 8] = captured.wdata[8 * i +: 8];
					end
				end
				dataio_rdata = mem[idx];
				dataio_ack = 1'b1;
				@(negedge iCLOCK);
				dataio_ack = 1'b0;
			end
		end
	end

	initial begin
		#(N_OPS * 200 * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", N_OPS * 200);
		$display("Checks failed");
		$finish;
	end

	initial begin
		int i;
		void'($urandom(32'h5fb0_055a));
		op = '0;
		inRESET = 1'b0;
		load_table();
		fill_expected();
		repeat (10) @(negedge iCLOCK);
		inRESET = 1'b1;
		@(negedge iCLOCK);
		compare("lock after reset", 32'(lock), 32'h0);
		compare("req after reset", 32'(dataio.req), 32'h0);
		compare("wb.valid after reset", 32'(wb.valid), 32'h0);
		compare("flags after reset", 32'(flags), 32'h0);
		fork
			watch_writebacks();
		join_none
		for (i = 0; i < N_OPS; i++) begin
			// Odd entries ask for a register write
			op = '{valid: 1'b1, unit: ops[i].unit, cmd: ops[i].cmd, order: ops[i].order,
				src0: ops[i].src0, src1: ops[i].src1, dest: 5'(i), writeback: i[0],
				flags_write: ops[i].flags_write};
			// Op is held until the stage lets it in
			while (lock === 1'b1) @(negedge iCLOCK);
			pend_q.push_back(i);
			@(negedge iCLOCK);
			if (ops[i].unit == exec_pkg::ALU && wb.valid !== 1'b1) begin
				other_errors++;
				$display("No writeback one cycle after ALU op %0d was accepted", i);
			end
			if (ops[i].unit != exec_pkg::ALU && lock !== 1'b1) begin
				other_errors++;
				$display("Lock stayed low after memory op %0d was accepted", i);
			end
		end
		op.valid = 1'b0;
		while (pend_q.size() != 0) @(negedge iCLOCK);
		repeat (2) @(negedge iCLOCK);
		$display("Error counts: %0d wrong values, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("All checks passed");
		end
		else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/exec_ldst.sv
verilog/exec_control.sv
verilog/exec_top.sv
dv/exec_asserts.sv
dv/exec_tb.sv

/* run.sh */
#!/bin/bash
# Build and run with Verilator, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns --top-module exec_tb \
	-f vlog.f -o exec_sim > build.log 2>&1 \
	&& ./obj_dir/exec_sim > sim.log 2>&1 \
	&& ! grep -q "Checks failed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see build.log and sim.log"; exit 1; }
